// File: build.f
+incdir+common
common/audioTxPkg.sv
common/romCtrlIf.sv
logic/audioTxCsr.sv
romRead/audioRomRead.sv
logic/sampleMixFifo.sv
logic/i2sTx.sv
logic/audioTxTop.sv
bench/audioTx_checker.sv
bench/audioTxTb.sv

// File: run.sh
#!/bin/sh
# Build the audio playback testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module audioTxTb -o audioTxSim

# A fatal check ends the simulation with a non-zero status, so keep the output
simOut=$(./obj_dir/audioTxSim 2>&1) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -q "ALL CHECKS PASSED"
then
	exit 0
fi
exit 1

// File: bench/audioTxTb.sv
/*
 * Audio playback testbench
 * Two serial flash models, stimulus table of voice setups,
 * I2S frame decoder, register checks and a watchdog
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module audioTxTb;

	localparam int     ClkPeriod = 10;
	localparam int     NumRows   = 5;
	localparam longint FrameNs   = 32 * 2 * `I2S_BCLK_DIV * ClkPeriod;
	localparam logic [31:0] Seed = 32'hb52e_fc03;

	// One voice setup per table row
	typedef struct packed
	{
		logic [1:0]  mask;
		logic [15:0] start0;
		logic [15:0] end0;
		logic [15:0] start1;
		logic [15:0] end1;
		logic        expectAlert;
	} rowT;

	// ------------------------------
	// Stimulus table
	// Row 1 restarts voice 0, row 3 saturates, row 4 fills the FIFO
	rowT stimTable [NumRows] = '{
		'{2'b01, 16'd0,   16'd9,   16'd0,   16'd0,   1'b0},
		'{2'b01, 16'd40,  16'd47,  16'd0,   16'd0,   1'b0},
		'{2'b11, 16'd5,   16'd14,  16'd20,  16'd29,  1'b0},
		'{2'b11, 16'd700, 16'd707, 16'd700, 16'd707, 1'b0},
		'{2'b11, 16'd100, 16'd179, 16'd200, 16'd279, 1'b1}
	};

	logic        iSCLK;
	logic        iSRST;
	logic        iWe;
	logic [7:0]  iAdrs;
	logic [31:0] iWd;
	logic [31:0] oRd;
	logic [1:0]  sfmSck;
	logic [1:0]  sfmMosi;
	wire  [1:0]  sfmMiso;
	logic [1:0]  sfmCs;
	logic        i2sBclk;
	logic        i2sLrclk;
	logic        i2sSdata;

	// Left halves of the decoded non-zero frames
	logic [15:0] frameQ [$];
	logic [31:0] frameBits = 32'd0;
	logic        lrPrev = 1'b0;

	audioTxTop dut_i (
		.iSCLK(iSCLK), .iSRST(iSRST), .iWe(iWe), .iAdrs(iAdrs), .iWd(iWd), .oRd(oRd),
		.oSfmSck(sfmSck), .oSfmMosi(sfmMosi), .iSfmMiso(sfmMiso), .oSfmCs(sfmCs),
		.oI2sBclk(i2sBclk), .oI2sLrclk(i2sLrclk), .oI2sSdata(i2sSdata)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #(ClkPeriod / 2) iSCLK = ~iSCLK;
	end

	// ------------------------------
	// Flash contents are positive and never zero
	function automatic logic [15:0] sampleWord(input int voice, input int idx);
		int raw;
		raw = ((idx * 37 + 100 + voice * 5000) % 32767) + 1;
		return raw[15:0];
	endfunction

	// Expected mix with a disabled voice as zero
	function automatic logic [15:0] mixExpect(input logic [1:0] mask, input int idx0,
		input int idx1);
		int sum;
		sum = 0;
		if (mask[0])
			sum = sum + int'(sampleWord(0, idx0));
		if (mask[1])
			sum = sum + int'(sampleWord(1, idx1));
		// Both inputs positive so only the top clips
		if (sum > 32767)
			sum = 32767;
		return sum[15:0];
	endfunction

	// Samples played by one row
	function automatic int rowCount(input int r);
		if (stimTable[r].mask[0])
			return int'(stimTable[r].end0) - int'(stimTable[r].start0) + 1;
		return int'(stimTable[r].end1) - int'(stimTable[r].start1) + 1;
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("** Error %s: expected %0h, actual %0h", testName, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ------------------------------
	// Serial flash models for the read command only
	for (genvar v = 0; v < `AUDIO_VOICES; v++)
	begin : flashModel
		int          edgeCnt = 0;
		logic [31:0] cmdAddr = 32'd0;
		logic [15:0] dataShift = 16'd0;
		logic        misoBit = 1'b0;

		assign sfmMiso[v] = misoBit;

		// Command and address in on SCK rise
		// Count cleared when CS rises
		always @(posedge sfmSck[v] or posedge sfmCs[v])
		begin
			if (sfmCs[v])
				edgeCnt = 0;
			else
			begin
				if (edgeCnt < 32)
					cmdAddr = {cmdAddr[30:0], sfmMosi[v]};
				edgeCnt = edgeCnt + 1;
			end
		end

		// Data out MSB first on SCK fall
		always @(negedge sfmSck[v])
		begin
			if (!sfmCs[v] && edgeCnt == 32)
			begin
				checkValue("flash command", 32'h03, {24'd0, cmdAddr[31:24]});
				// Byte address is twice the index
				dataShift = sampleWord(v, int'(cmdAddr[23:1]));
				misoBit = dataShift[15];
			end
			else if (!sfmCs[v] && edgeCnt > 32)
			begin
				dataShift = {dataShift[14:0], 1'b0};
				misoBit = dataShift[15];
			end
		end
	end

	// ------------------------------
	// I2S decoder
	// Data is stable on BCLK rise
	// The LSB of the right half lands in slot 0
	always @(posedge i2sBclk)
	begin
		frameBits = {frameBits[30:0], i2sSdata};
		if (lrPrev && !i2sLrclk)
		begin
			// Zero frames are underflow
			if (frameBits != 32'd0)
			begin
				checkValue("I2S left equals right", {16'd0, frameBits[31:16]},
					{16'd0, frameBits[15:0]});
				frameQ.push_back(frameBits[31:16]);
			end
		end
		lrPrev = i2sLrclk;
	end

	// ------------------------------
	// Register bus
	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
		@(posedge iSCLK);
		#1;
		iWe = 1'b1;
		iAdrs = addr;
		iWd = data;
		@(posedge iSCLK);
		#1;
		iWe = 1'b0;
	endtask

	// Combinational read mux sampled mid cycle
	task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
		@(posedge iSCLK);
		#1;
		iAdrs = addr;
		@(negedge iSCLK);
		data = oRd;
	endtask

	// One table row as setup then frame compare then status
	task automatic runRow(input int r);
		rowT         row;
		logic [31:0] rd;
		logic [15:0] expWord;
		logic [15:0] gotWord;
		logic        alertSeen;
		int          count;
		row = stimTable[r];
		count = rowCount(r);
		alertSeen = 1'b0;
		// Enable low first so the new enable is a rising edge
		writeReg(8'h00, 32'd0);
		writeReg(8'h10, {row.end0, row.start0});
		writeReg(8'h14, {row.end1, row.start1});
		readReg(8'h10, rd);
		checkValue($sformatf("row %0d cfg0", r), {row.end0, row.start0}, rd);
		readReg(8'h14, rd);
		checkValue($sformatf("row %0d cfg1", r), {row.end1, row.start1}, rd);
		writeReg(8'h00, {30'd0, row.mask});
		readReg(8'h00, rd);
		checkValue($sformatf("row %0d ctrl", r), {30'd0, row.mask}, rd);
		// Watch the status alert bit while frames arrive
		@(posedge iSCLK);
		#1;
		iAdrs = 8'h04;
		for (int i = 0; i < count; i++)
		begin
			while (frameQ.size() == 0)
			begin
				@(negedge iSCLK);
				if (oRd[8])
					alertSeen = 1'b1;
			end
			gotWord = frameQ.pop_front();
			expWord = mixExpect(row.mask, int'(row.start0) + i, int'(row.start1) + i);
			checkValue($sformatf("row %0d frame %0d", r, i), {16'd0, expWord},
				{16'd0, gotWord});
		end
		// Done bits follow the mask with the FIFO drained
		readReg(8'h04, rd);
		checkValue($sformatf("row %0d status", r), {30'd0, row.mask}, rd);
		if (row.mask[0])
		begin
			readReg(8'h20, rd);
			checkValue($sformatf("row %0d curIdx0", r), {16'd0, row.end0}, rd);
		end
		if (row.mask[1])
		begin
			readReg(8'h24, rd);
			checkValue($sformatf("row %0d curIdx1", r), {16'd0, row.end1}, rd);
		end
		if (row.expectAlert)
			checkValue($sformatf("row %0d FIFO alert", r), 32'd1, {31'd0, alertSeen});
		// Random idle gap
		repeat ($urandom_range(15, 0)) @(posedge iSCLK);
	endtask

	// ------------------------------
	// Main sequence
	initial
	begin : mainSeq
		logic [31:0] rd;
		iSRST = 1'b1;
		iWe = 1'b0;
		iAdrs = 8'h00;
		iWd = 32'd0;
		void'($urandom(Seed));
		repeat (10) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;
		// Unmapped and reset values
		readReg(8'h08, rd);
		checkValue("unmapped 0x08", 32'd0, rd);
		readReg(8'h30, rd);
		checkValue("unmapped 0x30", 32'd0, rd);
		readReg(8'hfc, rd);
		checkValue("unmapped 0xfc", 32'd0, rd);
		readReg(8'h04, rd);
		checkValue("status after reset", 32'd0, rd);
		for (int r = 0; r < NumRows; r++)
			runRow(r);
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// ------------------------------
	// Watchdog at twice the frame time of all rows plus setup slack
	initial
	begin : watchdog
		int     totalSamples;
		longint limitNs;
		totalSamples = 0;
		for (int r = 0; r < NumRows; r++)
			totalSamples = totalSamples + rowCount(r);
		limitNs = longint'(totalSamples) * FrameNs * 2 + NumRows * 8 * FrameNs;
		#(limitNs);
		$display("Timeout: the I2S frames did not all arrive in time");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: bench/audioTx_checker.sv
/*
 * Mix FIFO rule checker
 * Bound into the mixer FIFO
 * Flags writes into a full FIFO, pops from an empty one and fill overrun
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module audioTxChecker (
	input logic                                  iSCLK,
	input logic                                  iSRST,
	input logic                                  wrEn,
	input logic                                  iPop,
	input logic [$clog2(`AUDIO_FIFO_DEPTH):0]    fillCnt
);

	localparam int PtrW = $clog2(`AUDIO_FIFO_DEPTH);
	localparam logic [PtrW:0] Depth = (PtrW + 1)'(`AUDIO_FIFO_DEPTH);

	// ------------------------------
	// Write side
	noWriteWhenFull: assert property (@(posedge iSCLK) disable iff (iSRST)
		wrEn |-> (fillCnt < Depth))
		else $error("mix FIFO written while full");

	// Read side
	noPopWhenEmpty: assert property (@(posedge iSCLK) disable iff (iSRST)
		iPop |-> (fillCnt != '0))
		else $error("mix FIFO popped while empty");

	// Fill count range
	fillInRange: assert property (@(posedge iSCLK) disable iff (iSRST)
		fillCnt <= Depth)
		else $error("mix FIFO fill count above depth");

endmodule

bind sampleMixFifo audioTxChecker checker_i (
	.iSCLK(iSCLK), .iSRST(iSRST), .wrEn(wrEn), .iPop(iPop), .fillCnt(fillCnt)
);

// File: logic/audioTxTop.sv
/*
 * Audio playback top
 * Register file, two flash readers, mixer FIFO and I2S output
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module audioTxTop import audioTxPkg::*; (
	input  logic                     iSCLK,
	input  logic                     iSRST,
	// Register bus
	input  logic                     iWe,
	input  logic [7:0]               iAdrs,
	input  logic [31:0]              iWd,
	output logic [31:0]              oRd,
	// Serial flash, one bit per voice
	output logic [`AUDIO_VOICES-1:0] oSfmSck,
	output logic [`AUDIO_VOICES-1:0] oSfmMosi,
	input  logic [`AUDIO_VOICES-1:0] iSfmMiso,
	output logic [`AUDIO_VOICES-1:0] oSfmCs,
	// I2S
	output logic                     oI2sBclk,
	output logic                     oI2sLrclk,
	output logic                     oI2sSdata
);

	sampleT sample0;
	sampleT sample1;
	sampleT fifoHead;
	logic   valid0;
	logic   valid1;
	logic   room;
	logic   alert;
	logic   pop;
	logic   empty;

	romCtrlIf voice0If ();
	romCtrlIf voice1If ();

	// ------------------------------
	// Decode stage
	audioTxCsr csr_i (
		.iSCLK(iSCLK), .iSRST(iSRST), .iWe(iWe), .iAdrs(iAdrs), .iWd(iWd),
		.oRd(oRd), .iFifoAlert(alert), .voice0(voice0If), .voice1(voice1If)
	);

	// ------------------------------
	// Execute stage
	audioRomRead romRead0_i (
		.iSCLK(iSCLK), .iSRST(iSRST), .ctrl(voice0If), .iRoom(room),
		.oSample(sample0), .oValid(valid0), .oSfmSck(oSfmSck[0]),
		.oSfmMosi(oSfmMosi[0]), .iSfmMiso(iSfmMiso[0]), .oSfmCs(oSfmCs[0])
	);
	audioRomRead romRead1_i (
		.iSCLK(iSCLK), .iSRST(iSRST), .ctrl(voice1If), .iRoom(room),
		.oSample(sample1), .oValid(valid1), .oSfmSck(oSfmSck[1]),
		.oSfmMosi(oSfmMosi[1]), .iSfmMiso(iSfmMiso[1]), .oSfmCs(oSfmCs[1])
	);

	sampleMixFifo mixFifo_i (
		.iSCLK(iSCLK), .iSRST(iSRST), .iEnable({voice1If.enable, voice0If.enable}),
		.iSample0(sample0), .iValid0(valid0), .iSample1(sample1), .iValid1(valid1),
		.oRoom(room), .oAlert(alert), .iPop(pop), .oHead(fifoHead), .oEmpty(empty)
	);

	// ------------------------------
	// Result stage
	i2sTx i2sTx_i (
		.iSCLK(iSCLK), .iSRST(iSRST), .iHead(fifoHead), .iEmpty(empty), .oPop(pop),
		.oI2sBclk(oI2sBclk), .oI2sLrclk(oI2sLrclk), .oI2sSdata(oI2sSdata)
	);

endmodule

// File: logic/i2sTx.sv
/*
 * I2S serializer
 * 32 BCLK frame, same sample in both halves, MSB one BCLK after LRCLK
 * Pops one FIFO entry per frame, zero on underflow
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module i2sTx import audioTxPkg::*; (
	input  logic   iSCLK,
	input  logic   iSRST,
	input  sampleT iHead,
	input  logic   iEmpty,
	output logic   oPop,
	output logic   oI2sBclk,
	output logic   oI2sLrclk,
	output logic   oI2sSdata
);

	logic [7:0]  divCnt;
	logic [4:0]  slotCnt;
	logic [4:0]  slotNext;
	logic [31:0] frameShift;
	logic        bclkTick;
	logic        bclkFall;
	logic        frameStart;

	// BCLK half period tick
	assign bclkTick   = (divCnt == 8'(`I2S_BCLK_DIV - 1));
	assign bclkFall   = bclkTick & oI2sBclk;
	assign slotNext   = slotCnt + 5'd1;
	// LRCLK falling edge, start of left half
	assign frameStart = bclkFall & (slotNext == 5'd0);
	assign oPop       = frameStart & ~iEmpty;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			divCnt     <= '0;
			oI2sBclk   <= 1'b0;
			oI2sLrclk  <= 1'b0;
			oI2sSdata  <= 1'b0;
			// First falling edge opens a frame
			slotCnt    <= 5'd31;
			frameShift <= '0;
		end
		else
		begin
			divCnt <= bclkTick ? 8'd0 : divCnt + 8'd1;
			if (bclkTick)
				oI2sBclk <= ~oI2sBclk;
			// ------------------------------
			// Everything moves on BCLK fall
			if (bclkFall)
			begin
				slotCnt   <= slotNext;
				oI2sLrclk <= slotNext[4];
				// Last right LSB still goes out on the frame edge
				oI2sSdata <= frameShift[31];
				if (frameStart)
					frameShift <= iEmpty ? 32'd0 : {iHead, iHead};
				else
					frameShift <= {frameShift[30:0], 1'b0};
			end
		end
	end

endmodule

// File: logic/sampleMixFifo.sv
/*
 * Voice mixer and sample FIFO
 * Pairs pending samples, adds them with saturation, queues the sum
 * Fill count drives room for the readers and the alert flag
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module sampleMixFifo import audioTxPkg::*; (
	input  logic                     iSCLK,
	input  logic                     iSRST,
	input  logic [`AUDIO_VOICES-1:0] iEnable,
	input  sampleT                   iSample0,
	input  logic                     iValid0,
	input  sampleT                   iSample1,
	input  logic                     iValid1,
	output logic                     oRoom,
	output logic                     oAlert,
	input  logic                     iPop,
	output sampleT                   oHead,
	output logic                     oEmpty
);

	localparam int PtrW = $clog2(`AUDIO_FIFO_DEPTH);

	sampleT          pend0Data;
	sampleT          pend1Data;
	logic            pend0;
	logic            pend1;
	logic            wrEn;
	sampleT          mixIn0;
	sampleT          mixIn1;
	logic [16:0]     sumWide;
	sampleT          mixSum;
	sampleT          mem [`AUDIO_FIFO_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0]   fillCnt;

	// ------------------------------
	// Mixer
	// Disabled voice is zero and never waited on
	assign wrEn   = (pend0 | ~iEnable[0]) & (pend1 | ~iEnable[1]) & (|iEnable);
	assign mixIn0 = iEnable[0] ? pend0Data : '0;
	assign mixIn1 = iEnable[1] ? pend1Data : '0;
	assign sumWide = {mixIn0[15], mixIn0} + {mixIn1[15], mixIn1};

	// Clip on signed overflow
	always_comb
	begin
		case (sumWide[16:15])
			2'b01:   mixSum = 16'sh7fff;
			2'b10:   mixSum = 16'sh8000;
			default: mixSum = sumWide[15:0];
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			pend0 <= 1'b0;
			pend1 <= 1'b0;
		end
		else
		begin
			// New sample wins over the clear
			if (iValid0)
				pend0 <= 1'b1;
			else if (wrEn || !iEnable[0])
				pend0 <= 1'b0;
			if (iValid1)
				pend1 <= 1'b1;
			else if (wrEn || !iEnable[1])
				pend1 <= 1'b0;
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (iValid0)
			pend0Data <= iSample0;
		if (iValid1)
			pend1Data <= iSample1;
		if (wrEn)
			mem[wrPtr] <= mixSum;
	end

	// ------------------------------
	// Circular buffer pointers and fill
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			fillCnt <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (iPop)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, iPop})
				2'b10:   fillCnt <= fillCnt + 1'b1;
				2'b01:   fillCnt <= fillCnt - 1'b1;
				default: ;
			endcase
		end
	end

	assign oHead  = mem[rdPtr];
	assign oEmpty = (fillCnt == '0);
	assign oRoom  = (fillCnt < (PtrW + 1)'(`AUDIO_FIFO_ALERT));
	assign oAlert = ~oRoom;

endmodule

// File: romRead/audioRomRead.sv
/*
 * Serial flash sample reader, one per voice
 * Read command 0x03 per sample, SPI mode 0
 * Streams startIdx..endIdx, then flags done
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module audioRomRead import audioTxPkg::*; (
	input  logic     iSCLK,
	input  logic     iSRST,
	romCtrlIf.reader ctrl,
	input  logic     iRoom,
	output sampleT   oSample,
	output logic     oValid,
	output logic     oSfmSck,
	output logic     oSfmMosi,
	input  logic     iSfmMiso,
	output logic     oSfmCs
);

	// FSM states
	localparam logic [2:0] StIdle = 3'd0;
	localparam logic [2:0] StCmd  = 3'd1;
	localparam logic [2:0] StAddr = 3'd2;
	localparam logic [2:0] StData = 3'd3;
	localparam logic [2:0] StHold = 3'd4;
	localparam logic [2:0] StDone = 3'd5;

	logic [2:0]  state;
	logic [7:0]  divCnt;
	logic [4:0]  bitCnt;
	logic [7:0]  holdCnt;
	logic [31:0] txShift;
	logic [15:0] rxShift;
	logic [15:0] curIdx;
	logic        enPrev;
	logic        doneFlag;
	logic        busy;
	logic        sckTick;
	logic        sckRise;
	logic        dataEnd;

	// SCK runs only inside a transaction
	assign busy    = (state == StCmd) | (state == StAddr) | (state == StData);
	assign sckTick = busy & (divCnt == 8'(`SFM_SCK_DIV - 1));
	assign sckRise = sckTick & ~oSfmSck;
	// Falling edge after the last data bit
	assign dataEnd = sckTick & oSfmSck & (state == StData) & (bitCnt == 5'd15);

	assign oSfmMosi    = txShift[31];
	assign ctrl.curIdx = curIdx;
	assign ctrl.done   = doneFlag;

	// ------------------------------
	// Control FSM
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state    <= StIdle;
			divCnt   <= '0;
			bitCnt   <= '0;
			holdCnt  <= '0;
			txShift  <= '0;
			curIdx   <= '0;
			enPrev   <= 1'b0;
			doneFlag <= 1'b0;
			oSfmSck  <= 1'b0;
			oSfmCs   <= 1'b1;
			oValid   <= 1'b0;
		end
		else
		begin
			enPrev <= ctrl.enable;
			oValid <= 1'b0;
			divCnt <= sckTick ? 8'd0 : divCnt + 8'd1;
			if (!ctrl.enable)
			begin
				// Disabled: drop any read in flight
				state   <= StIdle;
				oSfmCs  <= 1'b1;
				oSfmSck <= 1'b0;
			end
			else if (!enPrev)
			begin
				// Rising enable restarts the voice
				curIdx   <= ctrl.startIdx;
				doneFlag <= 1'b0;
				state    <= StIdle;
			end
			else
			begin
				case (state)
					StIdle:
					begin
						// New read only with FIFO room
						if (iRoom)
						begin
							oSfmCs  <= 1'b0;
							txShift <= {8'h03, 7'd0, curIdx, 1'b0};
							bitCnt  <= '0;
							divCnt  <= '0;
							state   <= StCmd;
						end
					end
					StCmd, StAddr, StData:
					begin
						if (sckTick)
						begin
							oSfmSck <= ~oSfmSck;
							// MOSI moves on the falling edge
							if (oSfmSck)
							begin
								bitCnt  <= bitCnt + 5'd1;
								txShift <= {txShift[30:0], 1'b0};
								if ((state == StCmd) && (bitCnt == 5'd7))
								begin
									state  <= StAddr;
									bitCnt <= '0;
								end
								else if ((state == StAddr) && (bitCnt == 5'd23))
								begin
									state  <= StData;
									bitCnt <= '0;
								end
								else if (dataEnd)
								begin
									state   <= StHold;
									oSfmCs  <= 1'b1;
									oValid  <= 1'b1;
									holdCnt <= '0;
								end
							end
						end
					end
					StHold:
					begin
						// CS high gap, then next index or stop
						if (holdCnt == 8'(`SFM_CS_HOLD - 1))
						begin
							if (curIdx == ctrl.endIdx)
							begin
								doneFlag <= 1'b1;
								state    <= StDone;
							end
							else
							begin
								curIdx <= curIdx + 16'd1;
								state  <= StIdle;
							end
						end
						else
							holdCnt <= holdCnt + 8'd1;
					end
					// StDone waits for enable to drop
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// Data path, MSB first on SCK rise
	always_ff @(posedge iSCLK)
	begin
		if (sckRise && (state == StData))
			rxShift <= {rxShift[14:0], iSfmMiso};
		if (dataEnd)
			oSample <= rxShift;
	end

endmodule

// File: logic/audioTxCsr.sv
/*
 * Audio register file
 * Holds voice enables and sample index ranges
 * Read mux returns config, reader status and the FIFO alert
 */
`timescale 1ns/1ns
`include "audioTx_settings.svh"

module audioTxCsr import audioTxPkg::*; (
	input  logic        iSCLK,
	input  logic        iSRST,
	input  logic        iWe,
	input  logic [7:0]  iAdrs,
	input  csrWordT     iWd,
	output logic [31:0] oRd,
	input  logic        iFifoAlert,
	romCtrlIf.csr       voice0,
	romCtrlIf.csr       voice1
);

	logic [`AUDIO_VOICES-1:0] enReg;
	logic [15:0]              start0;
	logic [15:0]              end0;
	logic [15:0]              start1;
	logic [15:0]              end1;

	// ------------------------------
	// Write decode
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			enReg  <= '0;
			start0 <= '0;
			end0   <= '0;
			start1 <= '0;
			end1   <= '0;
		end
		else if (iWe)
		begin
			case (iAdrs)
				// Control, ctrl view
				8'h00: enReg <= iWd.ctrl.enable;
				// Voice ranges, chanCfg view
				8'h10:
				begin
					start0 <= iWd.chanCfg.startIdx;
					end0   <= iWd.chanCfg.endIdx;
				end
				8'h14:
				begin
					start1 <= iWd.chanCfg.startIdx;
					end1   <= iWd.chanCfg.endIdx;
				end
				// Status and index registers ignore writes
				default: ;
			endcase
		end
	end

	// Config out to readers
	assign voice0.enable   = enReg[0];
	assign voice0.startIdx = start0;
	assign voice0.endIdx   = end0;
	assign voice1.enable   = enReg[1];
	assign voice1.startIdx = start1;
	assign voice1.endIdx   = end1;

	// ------------------------------
	// Read mux, unmapped reads zero
	always_comb
	begin
		case (iAdrs)
			8'h00:   oRd = {30'd0, enReg};
			8'h04:   oRd = {23'd0, iFifoAlert, 6'd0, voice1.done, voice0.done};
			8'h10:   oRd = {end0, start0};
			8'h14:   oRd = {end1, start1};
			8'h20:   oRd = {16'd0, voice0.curIdx};
			8'h24:   oRd = {16'd0, voice1.curIdx};
			default: oRd = 32'd0;
		endcase
	end

endmodule

// File: common/romCtrlIf.sv
/*
 * Per-voice control bundle
 * Config from the register file, index and done status from the reader
 */
`timescale 1ns/1ns

interface romCtrlIf;

	// Config side
	logic        enable;
	logic [15:0] startIdx;
	logic [15:0] endIdx;

	// Status side
	logic [15:0] curIdx;
	logic        done;

	// Register file end
	modport csr (output enable, startIdx, endIdx,
		input curIdx, done);

	// Flash reader end
	modport reader (input enable, startIdx, endIdx,
		output curIdx, done);

endinterface

// File: common/audioTxPkg.sv
/*
 * Audio playback types
 * PCM sample word and the register write word with its two views
 */
package audioTxPkg;

	// Signed 16-bit PCM sample
	typedef logic signed [15:0] sampleT;

	// ------------------------------
	// Register write word
	// Address picks the view
	typedef union packed
	{
		// Voice config registers 0x10 / 0x14
		struct packed
		{
			logic [15:0] endIdx;
			logic [15:0] startIdx;
		} chanCfg;

		// Control register 0x00
		struct packed
		{
			logic [29:0] rsvd;
			// One enable bit per voice
			logic [1:0]  enable;
		} ctrl;
	} csrWordT;

endpackage

// File: common/audioTx_settings.svh
/*
 * Audio playback constants
 * Voice count, FIFO sizing, flash SPI and I2S bit clock timing
 */
`ifndef AUDIO_TX_SETTINGS_SVH
`define AUDIO_TX_SETTINGS_SVH

// ------------------------------
// Voices and FIFO
`define AUDIO_VOICES      2
`define AUDIO_FIFO_DEPTH  16
// Readers held at and above this fill
`define AUDIO_FIFO_ALERT  12

// ------------------------------
// Serial flash and I2S timing, in iSCLK cycles
`define SFM_SCK_DIV       2
`define SFM_CS_HOLD       4
`define I2S_BCLK_DIV      4

`endif
